// ==== verilog/dataIoPkg.sv ====
// ********************
// shared types and command codes for the SPI download path
// import with a wildcard in the module header of every stage
// that needs one of these definitions
// ********************

package dataIoPkg;

	// one byte as shifted in over SPI
	typedef logic [7:0] byte_t;

	// menu index of the file the host is sending
	typedef logic [4:0] fileIndex_t;

	// byte address in the target RAM, 25 bits fixed by the protocol
	typedef logic [24:0] ramAddr_t;

	// received byte plus its framing
	// isCommand marks the first byte of a select window
	typedef struct packed {
		logic  isCommand;
		byte_t data;
	} spiByte_t;

	// one numbered write towards the RAM
	typedef struct packed {
		ramAddr_t addr;
		byte_t    data;
	} ramWrite_t;

	// ********************
	// file transfer commands
	// ********************
	localparam byte_t cmdFileTx     = 8'h53;
	localparam byte_t cmdFileTxData = 8'h54;
	localparam byte_t cmdFileIndex  = 8'h55;

	// decode FSM, one state per command plus idle and ignore
	typedef enum logic [2:0] {idle, fileTx, fileData, fileIndex, ignore} controlState_t;

endpackage

// ==== verilog/spiByteReceiver.sv ====
// ********************
// SPI receive stage, runs entirely on sck
// shifts sdi in MSB first and presents each complete byte on rxData,
// flipping byteToggle on the same sck edge so that the clk side can
// pick the byte up; a falling spiSelect starts a new command
// ********************

`timescale 1ns/1ps

module spiByteReceiver import dataIoPkg::*; (
	input  logic     sck,
	input  logic     spiSelect,
	input  logic     sdi,
	input  logic     ss,
	output spiByte_t rxData,
	output logic     byteToggle
);

	// first seven bits of the byte in flight
	logic [6:0] shift;

	// 0..7 for the command byte, then 8..15 over and over for payload
	logic [3:0] bitCount;

	// last bit of a byte is on sdi now
	logic byteDone;

	assign byteDone = (bitCount[2:0] == 3'd7);

	// ********************
	// bit framing
	// ********************

	// deselect clears the framing so each window opens with a command
	always_ff @(posedge sck or posedge spiSelect or posedge ss) begin
		if (ss || spiSelect) begin
			shift    <= '0;
			bitCount <= '0;
		end else begin
			shift <= {shift[5:0], sdi};
			// wrap back into the payload phase, never to the command phase
			if (bitCount == 4'd15) begin
				bitCount <= 4'd8;
			end else begin
				bitCount <= bitCount + 4'd1;
			end
		end
	end

	// ********************
	// byte hand-off
	// ********************

	// rxData holds still for the next eight sck edges, long enough
	// for byteSync to sample it after the toggle has crossed
	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			rxData     <= '0;
			byteToggle <= 1'b0;
		end else if (byteDone) begin
			// eighth bit goes straight from sdi, it never enters the shifter
			rxData.data      <= {shift, sdi};
			// counter still below 8 means this was the command byte
			rxData.isCommand <= ~bitCount[3];
			byteToggle       <= ~byteToggle;
		end
	end

endmodule

// ==== verilog/byteSync.sv ====
// ********************
// clock domain crossing from sck to clk
// the toggle from spiByteReceiver passes two flip-flops, then an
// edge against a history flop copies the held byte and pulses rxValid
// ********************

`timescale 1ns/1ps

module byteSync import dataIoPkg::*; (
	input  logic     clk,
	input  logic     ss,
	input  spiByte_t rxData,
	input  logic     byteToggle,
	output logic     rxValid,
	output spiByte_t rxByte
);

	// two-stage synchronizer on the toggle
	logic toggleMeta;
	logic toggleSync;

	// value of toggleSync one clk earlier
	logic toggleHist;

	// a new byte is waiting in rxData
	logic newByte;

	assign newByte = toggleSync ^ toggleHist;

	// ********************
	// toggle synchronizer
	// ********************
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			toggleMeta <= 1'b0;
			toggleSync <= 1'b0;
			toggleHist <= 1'b0;
			rxValid    <= 1'b0;
		end else begin
			toggleMeta <= byteToggle;
			toggleSync <= toggleMeta;
			toggleHist <= toggleSync;
			// one pulse per flip in either direction
			rxValid    <= newByte;
		end
	end

	// rxData has been stable since the toggle flipped, so it is
	// safe to take the whole word here without a synchronizer
	always_ff @(posedge clk) begin
		if (newByte) begin
			rxByte <= rxData;
		end
	end

endmodule

// ==== verilog/downloadControl.sv ====
// ********************
// command decoder for the file transfer protocol
// a command byte selects the state, the payload bytes that follow
// start or stop a download, produce RAM writes or set the menu index
// ********************

`timescale 1ns/1ps

module downloadControl import dataIoPkg::*; (
	input  logic       clk,
	input  logic       ss,
	input  logic       rxValid,
	input  spiByte_t   rxByte,
	output logic       wrValid,
	output ramWrite_t  wrEntry,
	output logic       downloading,
	output fileIndex_t index
);

	controlState_t state;

	// address of the next file byte
	ramAddr_t addr;

	// ********************
	// command FSM
	// ********************
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			state       <= idle;
			addr        <= '0;
			downloading <= 1'b0;
			index       <= '0;
			wrValid     <= 1'b0;
		end else begin
			// write strobe is a single cycle
			wrValid <= 1'b0;
			if (rxValid) begin
				if (rxByte.isCommand) begin
					// first byte of a window picks what the payload means
					case (rxByte.data)
						cmdFileTx:     state <= fileTx;
						cmdFileTxData: state <= fileData;
						cmdFileIndex:  state <= fileIndex;
						default:       state <= ignore;
					endcase
				end else begin
					case (state)
						fileTx: begin
							// bit 0 opens a new file at address zero
							if (rxByte.data[0]) begin
								addr        <= '0;
								downloading <= 1'b1;
							end else begin
								downloading <= 1'b0;
							end
						end
						fileData: begin
							wrValid <= 1'b1;
							addr    <= addr + 1'b1;
						end
						fileIndex: begin
							index <= rxByte.data[4:0];
						end
						// idle and unknown commands drop their payload
						default: ;
					endcase
				end
			end
		end
	end

	// write payload, only meaningful while wrValid is high
	always_ff @(posedge clk) begin
		if (rxValid && !rxByte.isCommand && state == fileData) begin
			wrEntry.addr <= addr;
			wrEntry.data <= rxByte.data;
		end
	end

endmodule

// ==== verilog/writeQueue.sv ====
// ********************
// write buffer between the decoder and the external RAM
// entries leave one per cycle while credits remain; the RAM hands
// a credit back per creditReturn pulse. a push into a full queue is
// dropped and latches overflow until reset
// ********************

`timescale 1ns/1ps

module writeQueue import dataIoPkg::*; #(
	parameter int QueueDepth = 8,
	parameter int RamCredits = 4
) (
	input  logic      clk,
	input  logic      ss,
	input  logic      wrValid,
	input  ramWrite_t wrEntry,
	input  logic      creditReturn,
	output logic      ramValid,
	output ramWrite_t ramWrite,
	output logic      overflow
);

	localparam int PtrWidth    = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int FillWidth   = $clog2(QueueDepth + 1);
	localparam int CreditWidth = $clog2(RamCredits + 1);

	typedef logic [PtrWidth-1:0]    queuePtr_t;
	typedef logic [FillWidth-1:0]   queueFill_t;
	typedef logic [CreditWidth-1:0] credit_t;

	ramWrite_t  entries [QueueDepth];
	queuePtr_t  wrPtr;
	queuePtr_t  rdPtr;
	queueFill_t fill;
	credit_t    credits;

	logic full;
	logic empty;
	logic push;
	logic pop;

	// circular increment, depth need not be a power of two
	function automatic queuePtr_t nextPtr(queuePtr_t ptr);
		if (ptr == queuePtr_t'(QueueDepth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full  = (fill == queueFill_t'(QueueDepth));
	assign empty = (fill == '0);

	// issue whenever there is something to send and the RAM has room
	assign pop  = !empty && (credits != '0);
	// a slot freed by this cycle's pop can take the new entry
	assign push = wrValid && (!full || pop);

	assign ramValid = pop;
	assign ramWrite = entries[rdPtr];

	// ********************
	// storage
	// ********************
	always_ff @(posedge clk) begin
		if (push) begin
			entries[wrPtr] <= wrEntry;
		end
	end

	// ********************
	// pointers, fill and credits
	// ********************
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			fill     <= '0;
			credits  <= credit_t'(RamCredits);
			overflow <= 1'b0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: ;
			endcase
			// spend on issue, refill on return; both at once cancel
			case ({pop, creditReturn})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: ;
			endcase
			// sticky, a lost byte spoils the whole file
			if (wrValid && !push) begin
				overflow <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/dataIo.sv ====
// ********************
// SPI file download path of the I/O controller
// receive, synchronize, decode and queue in one pipeline; set
// QueueDepth and RamCredits here to match the RAM behind ramWrite
// ********************

`timescale 1ns/1ps

module dataIo import dataIoPkg::*; #(
	parameter int QueueDepth = 8,
	parameter int RamCredits = 4
) (
	input  logic       clk,
	input  logic       ss,
	input  logic       sck,
	input  logic       spiSelect,
	input  logic       sdi,
	input  logic       creditReturn,
	output logic       ramValid,
	output ramWrite_t  ramWrite,
	output logic       downloading,
	output fileIndex_t index,
	output logic       overflow
);

	// sck domain hand-off
	spiByte_t  rxData;
	logic      byteToggle;

	// clk domain byte stream
	logic      rxValid;
	spiByte_t  rxByte;

	// decoded writes into the queue
	logic      wrValid;
	ramWrite_t wrEntry;

	spiByteReceiver receiver0 (
		.sck        (sck),
		.spiSelect  (spiSelect),
		.sdi        (sdi),
		.ss         (ss),
		.rxData     (rxData),
		.byteToggle (byteToggle)
	);

	byteSync sync0 (
		.clk        (clk),
		.ss         (ss),
		.rxData     (rxData),
		.byteToggle (byteToggle),
		.rxValid    (rxValid),
		.rxByte     (rxByte)
	);

	downloadControl control0 (
		.clk         (clk),
		.ss          (ss),
		.rxValid     (rxValid),
		.rxByte      (rxByte),
		.wrValid     (wrValid),
		.wrEntry     (wrEntry),
		.downloading (downloading),
		.index       (index)
	);

	writeQueue #(
		.QueueDepth (QueueDepth),
		.RamCredits (RamCredits)
	) queue0 (
		.clk          (clk),
		.ss           (ss),
		.wrValid      (wrValid),
		.wrEntry      (wrEntry),
		.creditReturn (creditReturn),
		.ramValid     (ramValid),
		.ramWrite     (ramWrite),
		.overflow     (overflow)
	);

endmodule

// ==== tb/dataIo_assertions.sv ====
// ********************
// protocol checks for the download path, bound into dataIo
// covers reset values, the RAM credit limit and the timing of
// the downloading flag
// ********************

`timescale 1ns/1ps

module dataIoAssertions import dataIoPkg::*; #(
	parameter int RamCredits = 4
) (
	input logic          clk,
	input logic          ss,
	input logic          rxValid,
	input logic          ramValid,
	input logic          creditReturn,
	input logic          downloading,
	input logic          overflow,
	input fileIndex_t    index,
	input controlState_t controlState
);

	// writes issued to the RAM and not yet credited back
	int outstanding;

	// number of failed assertions
	int failCount = 0;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(ramValid) - int'(creditReturn);
		end
	end

	// ********************
	// reset
	// ********************

	// outputs stay quiet in reset and on the first cycle after it
	resetQuiet: assert property (@(posedge clk)
		(ss || $past(ss)) |-> (!ramValid && !downloading && !overflow))
	else begin
		$error("ramValid, downloading or overflow high around reset");
		failCount++;
	end

	resetState: assert property (@(posedge clk)
		ss |-> (index == '0 && controlState == idle))
	else begin
		$error("index or decoder state not cleared by reset");
		failCount++;
	end

	// ********************
	// RAM credits
	// ********************

	// no issue once every credit is spent
	creditLimit: assert property (@(posedge clk) disable iff (ss)
		(outstanding >= RamCredits) |-> !ramValid)
	else begin
		$error("ramValid with %0d writes outstanding", outstanding);
		failCount++;
	end

	// ********************
	// decoder timing
	// ********************

	// downloading moves only one cycle after a byte reached the decoder
	downloadTiming: assert property (@(posedge clk) disable iff (ss)
		$changed(downloading) |-> $past(rxValid))
	else begin
		$error("downloading changed without a received byte");
		failCount++;
	end

endmodule

bind dataIo dataIoAssertions #(.RamCredits(RamCredits)) checks0 (
	.clk          (clk),
	.ss           (ss),
	.rxValid      (rxValid),
	.ramValid     (ramValid),
	.creditReturn (creditReturn),
	.downloading  (downloading),
	.overflow     (overflow),
	.index        (index),
	.controlState (control0.state)
);

// ==== tb/dataIoTb.sv ====
// ********************
// testbench for the SPI download path
// an SPI host model sends commands and file data, a RAM model logs
// the writes and returns credits late; a scoreboard compares the log
// with the file that was sent
// ********************

`timescale 1ns/1ps

module dataIoTb import dataIoPkg::*; ();

	localparam int QueueDepth = 8;
	localparam int RamCredits = 4;
	localparam int FileLength = 64;
	// clk cycles any single wait may take
	localparam int WaitLimit  = 3000;

	logic       clk;
	logic       ss;
	logic       sck;
	logic       spiSelect;
	logic       sdi;
	logic       creditReturn;
	logic       ramValid;
	ramWrite_t  ramWrite;
	logic       downloading;
	fileIndex_t index;
	logic       overflow;

	// RAM model: write log and the cycle each credit falls due
	ramAddr_t addrLog[$];
	byte_t    dataLog[$];
	int       dueQ[$];
	int       cycleCount;
	logic     holdCredits;

	byte_t fileBytes[FileLength];
	int    seed;
	int    mismatches;
	int    timeouts;

	dataIo #(
		.QueueDepth (QueueDepth),
		.RamCredits (RamCredits)
	) dut0 (
		.clk          (clk),
		.ss           (ss),
		.sck          (sck),
		.spiSelect    (spiSelect),
		.sdi          (sdi),
		.creditReturn (creditReturn),
		.ramValid     (ramValid),
		.ramWrite     (ramWrite),
		.downloading  (downloading),
		.index        (index),
		.overflow     (overflow)
	);

	always #4 clk = ~clk;

	// ********************
	// RAM model
	// ********************
	always @(posedge clk) begin
		creditReturn <= 1'b0;
		if (ramValid) begin
			addrLog.push_back(ramWrite.addr);
			dataLog.push_back(ramWrite.data);
			// credit comes back 0 to 6 cycles later
			dueQ.push_back(cycleCount + int'($unsigned($random(seed)) % 7));
		end
		// at most one credit per cycle, oldest first
		if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
			creditReturn <= 1'b1;
			void'(dueQ.pop_front());
		end
		cycleCount++;
	end

	task automatic waitClocks(input int n);
		repeat (n) @(posedge clk);
	endtask

	// ********************
	// SPI host model
	// ********************

	// sck period is three clk cycles, sdi set up two cycles before the rise
	task automatic shiftByte(input byte_t value);
		for (int i = 7; i >= 0; i--) begin
			sck <= 1'b0;
			sdi <= value[i];
			waitClocks(2);
			sck <= 1'b1;
			@(posedge clk);
		end
	endtask

	task automatic openWindow();
		@(posedge clk);
		sck       <= 1'b0;
		spiSelect <= 1'b0;
		@(posedge clk);
	endtask

	// gap after deselect lets the last byte cross into clk
	task automatic closeWindow();
		@(posedge clk);
		sck       <= 1'b0;
		spiSelect <= 1'b1;
		waitClocks(12);
	endtask

	task automatic sendCommand(input byte_t cmd, input byte_t payload);
		openWindow();
		shiftByte(cmd);
		shiftByte(payload);
		closeWindow();
	endtask

	// one data window carrying count bytes of the file from first on
	task automatic sendData(input int first, input int count);
		openWindow();
		shiftByte(cmdFileTxData);
		for (int i = 0; i < count; i++) begin
			shiftByte(fileBytes[first + i]);
		end
		closeWindow();
	endtask

	task automatic stallCredits(input int cycles);
		@(posedge clk);
		holdCredits <= 1'b1;
		waitClocks(cycles);
		holdCredits <= 1'b0;
	endtask

	// ********************
	// waits, sampled on the falling edge
	// ********************
	task automatic waitIndex(input fileIndex_t expected);
		for (int n = 0; n < WaitLimit && index !== expected; n++) begin
			@(negedge clk);
		end
		if (index !== expected) begin
			$display("error at time %0t: index is %h, expected %h", $time, index, expected);
			mismatches++;
		end
	endtask

	task automatic waitDownloading(input logic expected);
		for (int n = 0; n < WaitLimit && downloading !== expected; n++) begin
			@(negedge clk);
		end
		if (downloading !== expected) begin
			$display("error at time %0t: downloading is %b, expected %b",
				$time, downloading, expected);
			mismatches++;
		end
	endtask

	task automatic waitWrites(input int count);
		for (int n = 0; n < WaitLimit && addrLog.size() < count; n++) begin
			@(negedge clk);
		end
		if (addrLog.size() < count) begin
			$display("timeout: only %0d of %0d writes reached the RAM", addrLog.size(), count);
			timeouts++;
		end
	endtask

	// every credit handed back and nothing issuing
	task automatic waitCreditsBack();
		for (int n = 0; n < WaitLimit && (dueQ.size() != 0 || ramValid || creditReturn);
				n++) begin
			@(negedge clk);
		end
		if (dueQ.size() != 0 || ramValid) begin
			$display("timeout: the RAM still holds credits or writes are still issuing");
			timeouts++;
		end
	endtask

	// watch for a while, any write is wrong
	task automatic expectNoWrites(input int cycles);
		for (int n = 0; n < cycles && addrLog.size() == 0; n++) begin
			@(negedge clk);
		end
		if (addrLog.size() != 0) begin
			$display("error at time %0t: unexpected write to address %h", $time, addrLog[0]);
			mismatches++;
		end
	endtask

	// ********************
	// scoreboard
	// ********************

	// file addresses start at 0, data comes from fileBytes[base] on
	task automatic checkWrites(input int base, input int count);
		if (addrLog.size() != count) begin
			$display("error at time %0t: %0d writes logged, expected %0d",
				$time, addrLog.size(), count);
			mismatches++;
		end
		for (int i = 0; i < addrLog.size() && i < count; i++) begin
			if (addrLog[i] != ramAddr_t'(i) || dataLog[i] != fileBytes[base + i]) begin
				$display("error at time %0t: write %0d was %h at %h, expected %h at %h",
					$time, i, dataLog[i], addrLog[i], fileBytes[base + i], i);
				mismatches++;
			end
		end
	endtask

	task automatic checkOverflow(input logic expected);
		if (overflow !== expected) begin
			$display("error at time %0t: overflow is %b, expected %b", $time, overflow, expected);
			mismatches++;
		end
	endtask

	task automatic clearLog();
		addrLog.delete();
		dataLog.delete();
	endtask

	initial begin
		clk          = 1'b0;
		ss           = 1'b1;
		sck          = 1'b0;
		spiSelect    = 1'b1;
		sdi          = 1'b0;
		creditReturn = 1'b0;
		holdCredits  = 1'b0;
		cycleCount   = 0;
		seed         = 88525;
		mismatches   = 0;
		timeouts     = 0;
		for (int i = 0; i < FileLength; i++) begin
			fileBytes[i] = byte_t'($random(seed));
		end
		waitClocks(2);
		ss <= 1'b0;
		waitClocks(4);

		// menu index keeps the low five bits
		sendCommand(cmdFileIndex, 8'h3A);
		waitIndex(5'h1A);

		// 40 byte file over two data windows
		sendCommand(cmdFileTx, 8'h01);
		waitDownloading(1'b1);
		sendData(0, 20);
		sendData(20, 20);
		waitWrites(40);
		waitCreditsBack();
		checkWrites(0, 40);

		// end of download, then an unknown command is dropped
		sendCommand(cmdFileTx, 8'h00);
		waitDownloading(1'b0);
		clearLog();
		sendCommand(8'hA7, 8'h11);
		expectNoWrites(60);

		// credits held for a while so the RAM runs out, queue absorbs it
		sendCommand(cmdFileTx, 8'h01);
		waitDownloading(1'b1);
		clearLog();
		fork
			sendData(40, 24);
			stallCredits(200);
		join
		waitWrites(24);
		waitCreditsBack();
		checkWrites(40, 24);
		checkOverflow(1'b0);

		// held through a 20 byte file, only credits plus queue get through
		sendCommand(cmdFileTx, 8'h01);
		clearLog();
		@(posedge clk);
		holdCredits <= 1'b1;
		sendData(0, 20);
		checkOverflow(1'b1);
		@(posedge clk);
		holdCredits <= 1'b0;
		waitWrites(QueueDepth + RamCredits);
		waitCreditsBack();
		checkWrites(0, QueueDepth + RamCredits);
		// sticky until reset
		checkOverflow(1'b1);

		$display("done: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, dut0.checks0.failCount);
		if (mismatches == 0 && timeouts == 0 && dut0.checks0.failCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== dataIo.f ====
verilog/dataIoPkg.sv
verilog/spiByteReceiver.sv
verilog/byteSync.sv
verilog/downloadControl.sv
verilog/writeQueue.sv
verilog/dataIo.sv
tb/dataIo_assertions.sv
tb/dataIoTb.sv

// ==== Makefile ====
# Verilator build and run of the SPI download path testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dataIoTb
FILELIST  = dataIo.f
LOG       = sim.log
RUNFLAGS  = +verilator+error+limit+100

.PHONY: sim clean

# the log decides, the simulator's own exit status does not
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
